/* tb.f */
+incdir+.
cpu_pkg.sv
control_unit.sv
imm_decode.sv
register_file.sv
alu.sv
pc_reg.sv
load_store_unit.sv
cpu.sv
tb_cpu.sv

/* tb_rv_model.svh */
//****************************************
// RV32I reference model for the testbench
// own registers and pc, predicts next pc,
// the memory request and the rd result
//****************************************
`ifndef tb_rv_model_svh
`define tb_rv_model_svh

logic [31:0] m_regs [32];
logic [31:0] m_pc;
mem_req_t    exp_req;
logic [31:0] exp_dnpc;
logic [4:0]  exp_rd;
logic        exp_rd_we;
logic [31:0] exp_rd_val;

function automatic void reset_model();
    for (int r = 0; r < 32; r++) begin
        m_regs[r] = 32'h0;
    end
    m_pc = reset_pc;
endfunction

// integer computation by funct3, alt selects sub / sra
function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
    case (f3)
        3'd0:    isa_alu = alt ? x - y : x + y;
        3'd1:    isa_alu = x << y[4:0];
        3'd2:    isa_alu = {31'b0, $signed(x) < $signed(y)};
        3'd3:    isa_alu = {31'b0, x < y};
        3'd4:    isa_alu = x ^ y;
        3'd5:    isa_alu = alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6:    isa_alu = x | y;
        default: isa_alu = x & y;
    endcase
endfunction

function automatic void predict(input logic [31:0] c);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] ea;
    logic [31:0] byte_sh;
    logic [31:0] half_sh;
    logic        taken;
    f3    = c[14:12];
    a     = m_regs[c[19:15]];
    b     = m_regs[c[24:20]];
    imm_i = {{20{c[31]}}, c[31:20]};
    imm_s = {{20{c[31]}}, c[31:25], c[11:7]};
    imm_b = {{20{c[31]}}, c[7], c[30:25], c[11:8], 1'b0};
    imm_u = {c[31:12], 12'h000};
    imm_j = {{12{c[31]}}, c[19:12], c[20], c[30:21], 1'b0};
    exp_req    = '0;
    exp_rd     = c[11:7];
    exp_rd_we  = 1'b0;
    exp_rd_val = 32'h0;
    exp_dnpc   = m_pc + 32'd4;
    case (c[6:0])
        op_lui: begin
            exp_rd_we  = 1'b1;
            exp_rd_val = imm_u;
        end
        op_auipc: begin
            exp_rd_we  = 1'b1;
            exp_rd_val = m_pc + imm_u;
        end
        op_jal: begin
            exp_rd_we  = 1'b1;
            exp_rd_val = m_pc + 32'd4;
            exp_dnpc   = m_pc + imm_j;
        end
        op_jalr: begin
            exp_rd_we  = 1'b1;
            exp_rd_val = m_pc + 32'd4;
            exp_dnpc   = (a + imm_i) & ~32'd1;
        end
        op_branch: begin
            case (f3)
                3'd0:    taken = (a == b);
                3'd1:    taken = (a != b);
                3'd4:    taken = ($signed(a) < $signed(b));
                3'd5:    taken = ($signed(a) >= $signed(b));
                3'd6:    taken = (a < b);
                3'd7:    taken = (a >= b);
                default: taken = 1'b0;
            endcase
            if (taken) begin
                exp_dnpc = m_pc + imm_b;
            end
        end
        op_load: begin
            ea           = a + imm_i;
            exp_req.re   = 1'b1;
            exp_req.addr = {ea[31:2], 2'b00};
            byte_sh      = mem[ea[9:2]] >> {ea[1:0], 3'b000};  // wanted byte in 7:0
            half_sh      = mem[ea[9:2]] >> {ea[1], 4'b0000};
            exp_rd_we    = 1'b1;
            case (f3)
                3'd0:    exp_rd_val = {{24{byte_sh[7]}}, byte_sh[7:0]};
                3'd1:    exp_rd_val = {{16{half_sh[15]}}, half_sh[15:0]};
                3'd4:    exp_rd_val = {24'h0, byte_sh[7:0]};
                3'd5:    exp_rd_val = {16'h0, half_sh[15:0]};
                default: exp_rd_val = mem[ea[9:2]];
            endcase
        end
        op_store: begin
            ea           = a + imm_s;
            exp_req.we   = 1'b1;
            exp_req.addr = {ea[31:2], 2'b00};
            case (f3)
                3'd0: begin
                    exp_req.wdata = b[7:0] * 32'h0101_0101;
                    exp_req.wmask = {ea[1:0] == 2'd3, ea[1:0] == 2'd2,
                                     ea[1:0] == 2'd1, ea[1:0] == 2'd0};
                end
                3'd1: begin
                    exp_req.wdata = b[15:0] * 32'h0001_0001;
                    exp_req.wmask = {{2{ea[1]}}, {2{~ea[1]}}};  // upper or lower half
                end
                default: begin
                    exp_req.wdata = b;
                    exp_req.wmask = 4'b1111;
                end
            endcase
        end
        op_imm: begin
            exp_rd_we  = 1'b1;
            exp_rd_val = isa_alu(f3, (f3 == 3'd5) && c[30], a, imm_i);
        end
        op_reg: begin
            exp_rd_we  = 1'b1;
            exp_rd_val = isa_alu(f3, c[30], a, b);
        end
        default: ;  // anything else retires as a no-op
    endcase
endfunction

function automatic void commit_model();
    if (exp_rd_we && exp_rd != 5'd0) begin
        m_regs[exp_rd] = exp_rd_val;
    end
    m_pc = exp_dnpc;
endfunction

`endif

/* tb_cpu.sv */
//****************************************
// testbench for the single-cycle RV32I cpu
// random instructions checked cycle by
// cycle against an ISA model
//****************************************
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int          reset_cycles  = 16;
    localparam int          reset_timeout = 40;
    localparam logic [31:0] lfsr_seed     = 32'he257_b748;
    localparam logic [19:0] mem_window    = 20'h00010;  // base regs point here
    localparam logic [31:0] nop_cmd       = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic [31:0] cmd;
    logic [31:0] mem_rdata;
    mem_req_t    mem_req;
    logic [31:0] pc;
    logic [31:0] dnpc;
    logic [31:0] mem [256];
    logic [31:0] lfsr = lfsr_seed;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    `include "tb_rv_model.svh"

    cpu dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .pc        (pc),
        .dnpc      (dnpc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic fb;
        rand_bits = 32'h0;
        for (int k = 0; k < n; k++) begin
            fb        = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr      = {lfsr[30:0], fb};
            rand_bits = {rand_bits[30:0], fb};
        end
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] mask);
        merge_bytes = old_word;
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) begin
                merge_bytes[8*k +: 8] = new_word[8*k +: 8];
            end
        end
    endfunction

    // data memory, read combinationally, written at the edge
    initial begin
        for (int w = 0; w < 256; w++) begin
            mem[w] = {8'(w), ~8'(w), 8'(w) ^ 8'ha5, 8'(w) + 8'h3c};
        end
    end

    assign mem_rdata = mem[mem_req.addr[9:2]];

    always @(posedge clk) begin
        if (mem_req.we) begin
            mem[mem_req.addr[9:2]] <= merge_bytes(mem[mem_req.addr[9:2]], mem_req.wdata,
                                                  mem_req.wmask);
        end
    end

    // reset held for 16 edges, random loads and stores on cmd meanwhile
    initial begin
        rst_n = 1'b0;
        cmd   = 32'h0;
        for (int k = 0; k < reset_cycles; k++) begin
            @(posedge clk);
            #5;
            if (k < reset_cycles - 1) begin
                cmd      = rand_bits(32);
                cmd[6:0] = (rand_bits(1) != 0) ? op_store : op_load;
            end
        end
        rst_n = 1'b1;
        cmd   = nop_cmd;
    end

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_u = {imm, rd, opc};
    endfunction

    function automatic logic is_known(input logic [6:0] opc);
        is_known = (opc == op_lui) || (opc == op_auipc) || (opc == op_jal) ||
                   (opc == op_jalr) || (opc == op_branch) || (opc == op_load) ||
                   (opc == op_store) || (opc == op_imm) || (opc == op_reg);
    endfunction

    // random OP or OP-IMM with legal funct7 bits
    function automatic logic [31:0] gen_alu(input logic rd_zero);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [6:0]  f7;
        f3 = 3'(rand_bits(3));
        rd = rd_zero ? 5'd0 : 5'(rand_bits(5));
        if (rand_bits(1) != 0) begin
            imm = 12'(rand_bits(12));
            if (f3 == 3'd1) begin
                imm = {7'b0, imm[4:0]};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, imm[10], 5'b0, imm[4:0]};  // srli or srai
            end
            gen_alu = enc_i(imm, 5'(rand_bits(5)), f3, rd, op_imm);
        end else begin
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) ? 7'b0100000 : 7'b0;
            gen_alu = {f7, 5'(rand_bits(5)), 5'(rand_bits(5)), f3, rd, op_reg};
        end
    endfunction

    function automatic logic [4:0] pick_base(input logic [4:0] avoid);
        pick_base = 5'(rand_bits(5));
        if (pick_base == 5'd0 || pick_base == avoid) begin
            pick_base = (avoid == 5'd31) ? 5'd30 : 5'd31;
        end
    endfunction

    task automatic compare(input string field, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, field, expected, actual);
        end
    endtask

    // called mid-cycle with the prediction in place, returns after the next edge
    task automatic check_cycle();
        compare("pc", m_pc, pc);
        compare("dnpc", exp_dnpc, dnpc);
        compare("mem_req.we", {31'b0, exp_req.we}, {31'b0, mem_req.we});
        compare("mem_req.re", {31'b0, exp_req.re}, {31'b0, mem_req.re});
        if (exp_req.we || exp_req.re) begin
            compare("mem_req.addr", exp_req.addr, mem_req.addr);
        end
        if (exp_req.we) begin
            compare("mem_req.wmask", {28'b0, exp_req.wmask}, {28'b0, mem_req.wmask});
            compare("mem_req.wdata", exp_req.wdata, mem_req.wdata);
        end
        commit_model();
        @(posedge clk);
        #5;
    endtask

    task automatic issue(input logic [31:0] c);
        cmd = c;
        predict(c);
        @(negedge clk);
        check_cycle();
    endtask

    task automatic store_reg(input logic [4:0] data_reg);
        logic [4:0] base;
        base = pick_base(data_reg);
        issue(enc_u(mem_window, base, op_lui));
        issue(enc_s(12'(rand_bits(12)), data_reg, base, 3'd2));
    endtask

    task automatic store_random(output logic [11:0] off);
        logic [4:0] data_reg;
        logic [4:0] base;
        logic [2:0] f3;
        data_reg = 5'(rand_bits(5));
        base     = pick_base(data_reg);
        f3       = 3'(rand_bits(2));
        if (f3 == 3'd3) begin
            f3 = 3'd2;
        end
        off = 12'(rand_bits(12));
        issue(enc_u(mem_window, base, op_lui));
        issue(enc_s(off, data_reg, base, f3));
    endtask

    task automatic load_to(input logic [4:0] rd, input logic [11:0] off, input logic [2:0] f3);
        logic [4:0] base;
        base = pick_base(5'd0);
        issue(enc_u(mem_window, base, op_lui));
        issue(enc_i(off, base, f3, rd, op_load));
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    initial begin
        int          n;
        int          start;
        logic [31:0] c;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] off;
        reset_model();
        start = errors;
        n = 0;
        while (rst_n !== 1'b1 && n < reset_timeout) begin
            @(negedge clk);
            if (rst_n !== 1'b1) begin
                checks++;
                if (mem_req.we !== 1'b0 || mem_req.re !== 1'b0) begin
                    errors++;
                    $display("memory request issued at %0t while reset was low", $time);
                end
            end
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("Finished with errors");
            $finish;
        end else begin
            predict(cmd);  // nop already on cmd at release
            check_cycle();
            report_test("reset", start);
        end

        // every register gets a defined value first
        for (int r = 1; r < 32; r++) begin
            issue(enc_u(20'(rand_bits(20)), 5'(r), op_lui));
            issue(enc_i(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r), op_imm));
        end

        start = errors;
        for (int k = 0; k < 60; k++) begin
            c = gen_alu(1'b0);
            issue(c);
            store_reg(c[11:7]);
        end
        report_test("alu_ops", start);

        start = errors;
        for (int k = 0; k < 60; k++) begin
            rd  = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            case (rand_bits(2))
                0, 1: begin
                    rs2 = (rand_bits(1) != 0) ? rs1 : 5'(rand_bits(5));  // equal operands too
                    f3  = 3'(rand_bits(3));
                    if (f3[2:1] == 2'b01) begin
                        f3[1] = 1'b0;
                    end
                    issue({7'(rand_bits(7)), rs2, rs1, f3, 5'(rand_bits(5)), op_branch});
                end
                2: begin
                    issue(enc_u(20'(rand_bits(20)), rd, op_jal));
                    store_reg(rd);
                end
                default: begin
                    issue(enc_i(12'(rand_bits(12)), rs1, 3'd0, rd, op_jalr));
                    store_reg(rd);
                end
            endcase
        end
        report_test("control_flow", start);

        start = errors;
        for (int k = 0; k < 50; k++) begin
            store_random(off);
        end
        report_test("store_lanes", start);

        start = errors;
        for (int k = 0; k < 40; k++) begin
            store_random(off);
            f3 = 3'(rand_bits(3));
            if (f3 > 3'd4) begin
                f3 = f3 - 3'd3;
            end
            f3 = (f3 > 3'd2) ? f3 + 3'd1 : f3;  // lb lh lw lbu lhu
            rd = 5'(rand_bits(5));
            load_to(rd, off ^ {10'b0, 2'(rand_bits(2))}, f3);
            store_reg(rd);
        end
        report_test("load_extend", start);

        start = errors;
        for (int k = 0; k < 20; k++) begin
            c = rand_bits(32);
            if (is_known(c[6:0])) begin
                c[1:0] = 2'b00;  // compressed space, never a base opcode
            end
            issue(c);
            issue(gen_alu(1'b1));
            issue(enc_u(20'(rand_bits(20)), 5'd0, op_lui));
            load_to(5'd0, 12'(rand_bits(12)), 3'd2);
            store_reg(5'd0);
            store_reg(5'(rand_bits(5)));
        end
        report_test("side_effects", start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu.sv */
//****************************************
// cpu
// single-cycle RV32I core, one instruction
// retired per clock, data memory outside
//****************************************
`default_nettype none

module cpu (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire  [31:0]              cmd,
    input  wire  [cpu_pkg::xlen-1:0] mem_rdata,
    output cpu_pkg::mem_req_t        mem_req,
    output logic [cpu_pkg::xlen-1:0] pc,
    output logic [cpu_pkg::xlen-1:0] dnpc
);
    import cpu_pkg::*;

    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rs1_idx;
    logic [reg_addr_w-1:0] rs2_idx;
    logic [reg_addr_w-1:0] rd_idx;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       alu_a;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       load_data;
    logic [xlen-1:0]       wb_data;
    logic                  less;
    logic                  zero;

    // U format has no rs1 field, lui reads x0 instead
    assign rs1_idx = (ctrl.imm_kind == imm_u) ? '0 : cmd[19:15];
    assign rs2_idx = cmd[24:20];
    assign rd_idx  = cmd[11:7];

    control_unit u_control (
        .cmd   (cmd),
        .less  (less),
        .zero  (zero),
        .rst_n (rst_n),
        .ctrl  (ctrl)
    );

    imm_decode u_imm (
        .cmd      (cmd),
        .imm_kind (ctrl.imm_kind),
        .imm      (imm)
    );

    register_file u_regs (
        .clk     (clk),
        .raddr_a (rs1_idx),
        .raddr_b (rs2_idx),
        .waddr   (rd_idx),
        .wdata   (wb_data),
        .wen     (ctrl.reg_we),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    assign alu_a = (ctrl.a_src == a_pc) ? pc : rs1_data;

    always_comb begin
        case (ctrl.b_src)
            b_rs2:   alu_b = rs2_data;
            b_imm:   alu_b = imm;
            default: alu_b = 32'd4;  // link value
        endcase
    end

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .less   (less),
        .zero   (zero)
    );

    pc_reg u_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs1         (rs1_data),
        .imm         (imm),
        .pc_rel      (ctrl.pc_rel),
        .pc_base_rs1 (ctrl.pc_base_rs1),
        .pc          (pc),
        .dnpc        (dnpc)
    );

    load_store_unit u_lsu (
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .addr       (alu_result),  // effective address
        .store_data (rs2_data),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .load_data  (load_data)
    );

    assign wb_data = ctrl.load ? load_data : alu_result;

endmodule

`default_nettype wire

/* load_store_unit.sv */
//****************************************
// load/store unit
// store lane placement and byte mask,
// load lane extraction and extension
//****************************************
`default_nettype none

module load_store_unit (
    input  wire                       rst_n,
    input  wire  cpu_pkg::ctrl_t      ctrl,
    input  wire  [cpu_pkg::xlen-1:0]  addr,
    input  wire  [cpu_pkg::xlen-1:0]  store_data,
    input  wire  [cpu_pkg::xlen-1:0]  mem_rdata,
    output cpu_pkg::mem_req_t         mem_req,
    output logic [cpu_pkg::xlen-1:0]  load_data
);
    import cpu_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        sext;

    always_comb begin
        mem_req.addr = {addr[xlen-1:2], 2'b00};
        mem_req.we   = ctrl.store & rst_n;
        mem_req.re   = ctrl.load & rst_n;
        case (ctrl.mem_size)
            size_byte: begin
                mem_req.wdata = {4{store_data[7:0]}};  // same byte on every lane
                mem_req.wmask = 4'b0001 << addr[1:0];
            end
            size_half: begin
                mem_req.wdata = {2{store_data[15:0]}};
                mem_req.wmask = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                mem_req.wdata = store_data;
                mem_req.wmask = 4'b1111;
            end
        endcase
        if (!ctrl.store) begin
            mem_req.wmask = 4'b0000;
        end
    end

    always_comb begin
        case (addr[1:0])
            2'b00:   byte_lane = mem_rdata[7:0];
            2'b01:   byte_lane = mem_rdata[15:8];
            2'b10:   byte_lane = mem_rdata[23:16];
            default: byte_lane = mem_rdata[31:24];
        endcase
    end

    assign half_lane = addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];  // bit 0 ignored

    always_comb begin
        case (ctrl.mem_size)
            size_byte: begin
                sext      = byte_lane[7] & !ctrl.mem_unsigned;
                load_data = {{24{sext}}, byte_lane};
            end
            size_half: begin
                sext      = half_lane[15] & !ctrl.mem_unsigned;
                load_data = {{16{sext}}, half_lane};
            end
            default: begin
                sext      = 1'b0;
                load_data = mem_rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

/* pc_reg.sv */
//****************************************
// program counter
// next-pc select and the pc register
//****************************************
`default_nettype none

module pc_reg (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire  [cpu_pkg::xlen-1:0] rs1,
    input  wire  [cpu_pkg::xlen-1:0] imm,
    input  wire                      pc_rel,
    input  wire                      pc_base_rs1,
    output logic [cpu_pkg::xlen-1:0] pc,
    output logic [cpu_pkg::xlen-1:0] dnpc
);
    import cpu_pkg::*;

    logic [xlen-1:0] jalr_target;

    assign jalr_target = rs1 + imm;

    always_comb begin
        if (pc_base_rs1) begin
            dnpc = {jalr_target[xlen-1:1], 1'b0};
        end else if (pc_rel) begin
            dnpc = pc + imm;
        end else begin
            dnpc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

`default_nettype wire

/* alu.sv */
//****************************************
// ALU
// arithmetic, shift, compare and logic ops
// with less and zero flags for branches
//****************************************
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e          op,
    input  wire  [cpu_pkg::xlen-1:0]  a,
    input  wire  [cpu_pkg::xlen-1:0]  b,
    output logic [cpu_pkg::xlen-1:0]  result,
    output logic                      less,
    output logic                      zero
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // unsigned compare only for sltu, signed otherwise
    assign less = (op == alu_sltu) ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt,
            alu_sltu: result = {{(xlen - 1){1'b0}}, less};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* register_file.sv */
//****************************************
// register file
// 2 read ports, 1 write port, x0 reads zero
//****************************************
`default_nettype none

module register_file (
    input  wire                            clk,
    input  wire  [cpu_pkg::reg_addr_w-1:0] raddr_a,
    input  wire  [cpu_pkg::reg_addr_w-1:0] raddr_b,
    input  wire  [cpu_pkg::reg_addr_w-1:0] waddr,
    input  wire  [cpu_pkg::xlen-1:0]       wdata,
    input  wire                            wen,
    output logic [cpu_pkg::xlen-1:0]       rdata_a,
    output logic [cpu_pkg::xlen-1:0]       rdata_b
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [1:(1 << reg_addr_w) - 1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

/* imm_decode.sv */
//****************************************
// immediate decoder
// rebuilds the sign-extended I/S/B/U/J imm
//****************************************
`default_nettype none

module imm_decode (
    input  wire [31:0]         cmd,
    input  cpu_pkg::imm_kind_e imm_kind,
    output logic [31:0]        imm
);
    import cpu_pkg::*;

    always_comb begin
        case (imm_kind)
            imm_i:   imm = {{20{cmd[31]}}, cmd[31:20]};
            imm_s:   imm = {{20{cmd[31]}}, cmd[31:25], cmd[11:7]};
            imm_b:   imm = {{19{cmd[31]}}, cmd[31], cmd[7], cmd[30:25], cmd[11:8], 1'b0};
            imm_u:   imm = {cmd[31:12], 12'b0};
            imm_j:   imm = {{11{cmd[31]}}, cmd[31], cmd[19:12], cmd[20], cmd[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* control_unit.sv */
//****************************************
// control unit
// decodes an instruction into the control
// word and resolves branch conditions
//****************************************
`default_nettype none

module control_unit (
    input  wire  [31:0]   cmd,
    input  wire           less,
    input  wire           zero,
    input  wire           rst_n,
    output cpu_pkg::ctrl_t ctrl
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       taken;

    // funct3 plus the alternate bit (cmd[30]) to an ALU operation
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  funct_to_alu = alt ? alu_sub : alu_add;
            3'b001:  funct_to_alu = alu_sll;
            3'b010:  funct_to_alu = alu_slt;
            3'b011:  funct_to_alu = alu_sltu;
            3'b100:  funct_to_alu = alu_xor;
            3'b101:  funct_to_alu = alt ? alu_sra : alu_srl;
            3'b110:  funct_to_alu = alu_or;
            default: funct_to_alu = alu_and;
        endcase
    endfunction

    assign opcode = cmd[6:0];
    assign funct3 = cmd[14:12];

    always_comb begin
        case (funct3)
            3'b000:         taken = zero;   // beq
            3'b001:         taken = !zero;  // bne
            3'b100, 3'b110: taken = less;   // blt, bltu
            3'b101, 3'b111: taken = !less;  // bge, bgeu
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl          = '0;
        ctrl.imm_kind = imm_none;
        ctrl.alu_op   = alu_add;
        ctrl.a_src    = a_rs1;
        ctrl.b_src    = b_rs2;
        ctrl.mem_size = size_word;
        case (opcode)
            op_lui: begin
                ctrl.imm_kind = imm_u;  // x0 + imm
                ctrl.b_src    = b_imm;
                ctrl.reg_we   = 1'b1;
            end
            op_auipc: begin
                ctrl.imm_kind = imm_u;
                ctrl.a_src    = a_pc;
                ctrl.b_src    = b_imm;
                ctrl.reg_we   = 1'b1;
            end
            op_jal, op_jalr: begin
                ctrl.imm_kind    = (opcode == op_jal) ? imm_j : imm_i;
                ctrl.a_src       = a_pc;   // link value pc + 4
                ctrl.b_src       = b_four;
                ctrl.reg_we      = 1'b1;
                ctrl.pc_rel      = (opcode == op_jal);
                ctrl.pc_base_rs1 = (opcode == op_jalr);
            end
            op_branch: begin
                ctrl.imm_kind = imm_b;
                ctrl.alu_op   = funct3[2] ? (funct3[1] ? alu_sltu : alu_slt) : alu_sub;
                ctrl.pc_rel   = taken;
            end
            op_load, op_store: begin
                ctrl.imm_kind     = (opcode == op_load) ? imm_i : imm_s;
                ctrl.b_src        = b_imm;
                ctrl.reg_we       = (opcode == op_load);
                ctrl.load         = (opcode == op_load);
                ctrl.store        = (opcode == op_store);
                ctrl.mem_size     = mem_size_e'(funct3[1:0]);
                ctrl.mem_unsigned = funct3[2];
            end
            op_imm: begin
                ctrl.imm_kind = imm_i;
                ctrl.b_src    = b_imm;
                ctrl.alu_op   = funct_to_alu(funct3, (funct3 == 3'b101) && cmd[30]);
                ctrl.reg_we   = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op = funct_to_alu(funct3, cmd[30]);
                ctrl.reg_we = 1'b1;
            end
            default: ;  // fence, system etc. retire as no-op
        endcase
        if (!rst_n) begin
            ctrl.reg_we = 1'b0;
            ctrl.load   = 1'b0;
            ctrl.store  = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* cpu_pkg.sv */
//****************************************
// cpu package
// opcodes, ALU codes, control word and
// data memory port types for the RV32I core
//****************************************
`default_nettype none

package cpu_pkg;

    localparam int          xlen       = 32;
    localparam int          reg_addr_w = 5;
    localparam logic [31:0] reset_pc   = 32'h0;

    // base opcodes, bits 6:0 of the instruction
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [2:0] {
        imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
    } imm_kind_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic {a_rs1, a_pc} a_src_e;

    typedef enum logic [1:0] {b_rs2, b_imm, b_four} b_src_e;

    // same coding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

    typedef struct packed {
        imm_kind_e imm_kind;
        alu_op_e   alu_op;
        a_src_e    a_src;
        b_src_e    b_src;
        logic      reg_we;
        logic      load;
        logic      store;
        mem_size_e mem_size;
        logic      mem_unsigned;
        logic      pc_rel;       // jal or taken branch
        logic      pc_base_rs1;  // jalr
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] addr;   // word aligned
        logic [xlen-1:0] wdata;
        logic [3:0]      wmask;
        logic            we;
        logic            re;
    } mem_req_t;

endpackage

`default_nettype wire
